// File: ahb_biu_consts.svh
////////////////////////////////////////////////////////////
// AHB bus interface unit constants
// bus widths, request buffer depth and AHB3-Lite codes
////////////////////////////////////////////////////////////

`ifndef AHB_BIU_CONSTS_SVH
`define AHB_BIU_CONSTS_SVH

`define ADDR_W         32
`define DATA_W         32
`define REQ_DEPTH      4              // request buffer entries

// htrans codes, only single transfers are issued
`define HTRANS_IDLE    2'b00
`define HTRANS_NONSEQ  2'b10

`define HSIZE_BYTE     3'b000
`define HSIZE_HWORD    3'b001
`define HSIZE_WORD     3'b010

`define HBURST_SINGLE  3'b000
`define HPROT_DFLT     4'b0011        // data, privileged, non-buff, non-cache

// slave answers ERROR where (addr & mask) == base
`define ERR_BASE       32'h0000_1000
`define ERR_MASK       32'hffff_f000

`endif

// File: ahb_biu_pkg.sv
////////////////////////////////////////////////////////////
// AHB bus interface unit package
// vector types for the Wishbone and AHB sides and the
// data phase state of the AHB master
////////////////////////////////////////////////////////////

`include "ahb_biu_consts.svh"

package ahb_biu_pkg;

  //////////////////////////////////////////////////////////
  // bus vectors
  //////////////////////////////////////////////////////////

  // byte address, on AHB the low bits carry the lane offset
  typedef logic [`ADDR_W-1:0]   addr_t;

  typedef logic [`DATA_W-1:0]   data_t;     // one bus word

  // wishbone byte lane selects, one per data byte
  typedef logic [`DATA_W/8-1:0] sel_t;

  //////////////////////////////////////////////////////////
  // ahb control fields
  //////////////////////////////////////////////////////////

  typedef logic [2:0]           hsize_t;    // byte, hword, word
  typedef logic [1:0]           htrans_t;   // idle or nonseq here
  typedef logic [3:0]           hprot_t;

  //////////////////////////////////////////////////////////
  // master data phase
  //////////////////////////////////////////////////////////

  // busy from the accepted address phase until the
  // HREADY cycle that closes the data phase
  typedef enum logic
  {
    DP_IDLE = 1'b0,   // no transfer in data phase
    DP_BUSY = 1'b1    // data phase in progress
  } dphase_t;

endpackage

// File: ahb_biu_top.sv
////////////////////////////////////////////////////////////
// AHB bus interface unit top
// wishbone capture, request buffer and AHB3-Lite master
////////////////////////////////////////////////////////////

module ahb_biu_top
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  // wishbone classic slave port
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  ahb_biu_pkg::addr_t   wb_adr_i,
  input  ahb_biu_pkg::data_t   wb_dat_i,
  input  ahb_biu_pkg::sel_t    wb_sel_i,
  output ahb_biu_pkg::data_t   wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 wr_err_o,
  // AHB3-Lite master port
  output logic                 HSEL,
  output ahb_biu_pkg::addr_t   HADDR,
  output logic                 HWRITE,
  output ahb_biu_pkg::hsize_t  HSIZE,
  output logic [2:0]           HBURST,
  output ahb_biu_pkg::hprot_t  HPROT,
  output ahb_biu_pkg::htrans_t HTRANS,
  output logic                 HMASTLOCK,
  output ahb_biu_pkg::data_t   HWDATA,
  input  ahb_biu_pkg::data_t   HRDATA,
  input  logic                 HREADY,
  input  logic                 HRESP
);
  import ahb_biu_pkg::*;

  // push side
  logic   push;
  logic   push_we;
  addr_t  push_addr;
  hsize_t push_size;
  data_t  push_data;
  logic   full;
  // pop side, buffer head
  logic   pop;
  logic   empty;
  logic   head_we;
  addr_t  head_addr;
  hsize_t head_size;
  data_t  head_data;
  // completions back to the core side
  logic   rsp_valid;
  logic   rsp_we;
  logic   rsp_err;
  data_t  rsp_rdata;

  // wishbone pins and clock by name
  wb_req_capture u_capture
  (
    .push_o      (push),
    .push_we_o   (push_we),
    .push_addr_o (push_addr),
    .push_size_o (push_size),
    .push_data_o (push_data),
    .full_i      (full),
    .rsp_valid_i (rsp_valid),
    .rsp_we_i    (rsp_we),
    .rsp_err_i   (rsp_err),
    .rsp_rdata_i (rsp_rdata),
    .*
  );

  req_fifo u_fifo
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .push_i      (push),
    .push_we_i   (push_we),
    .push_addr_i (push_addr),
    .push_size_i (push_size),
    .push_data_i (push_data),
    .full_o      (full),
    .pop_i       (pop),
    .empty_o     (empty),
    .head_we_o   (head_we),
    .head_addr_o (head_addr),
    .head_size_o (head_size),
    .head_data_o (head_data)
  );

  // AHB pins and clock by name
  ahb_master u_master
  (
    .empty_i     (empty),
    .head_we_i   (head_we),
    .head_addr_i (head_addr),
    .head_size_i (head_size),
    .head_data_i (head_data),
    .pop_o       (pop),
    .rsp_valid_o (rsp_valid),
    .rsp_we_o    (rsp_we),
    .rsp_err_o   (rsp_err),
    .rsp_rdata_o (rsp_rdata),
    .*
  );

endmodule

// File: ahb_master.sv
////////////////////////////////////////////////////////////
// AHB3-Lite master
// turns buffered requests into single transfers with
// overlapped address and data phases; on an ERROR response
// the pending address phase is cancelled and reissued
////////////////////////////////////////////////////////////

`include "ahb_biu_consts.svh"

module ahb_master
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  // request buffer head
  input  logic                 empty_i,
  input  logic                 head_we_i,
  input  ahb_biu_pkg::addr_t   head_addr_i,
  input  ahb_biu_pkg::hsize_t  head_size_i,
  input  ahb_biu_pkg::data_t   head_data_i,
  output logic                 pop_o,
  // completion, one strobe per transfer
  output logic                 rsp_valid_o,
  output logic                 rsp_we_o,
  output logic                 rsp_err_o,
  output ahb_biu_pkg::data_t   rsp_rdata_o,
  // AHB3-Lite master port
  output logic                 HSEL,
  output ahb_biu_pkg::addr_t   HADDR,
  output logic                 HWRITE,
  output ahb_biu_pkg::hsize_t  HSIZE,
  output logic [2:0]           HBURST,
  output ahb_biu_pkg::hprot_t  HPROT,
  output ahb_biu_pkg::htrans_t HTRANS,
  output logic                 HMASTLOCK,
  output ahb_biu_pkg::data_t   HWDATA,
  input  ahb_biu_pkg::data_t   HRDATA,
  input  logic                 HREADY,
  input  logic                 HRESP
);
  import ahb_biu_pkg::*;

  dphase_t dp_state;
  logic    dp_we;         // write flag of data phase transfer
  data_t   dp_wdata;      // drives HWDATA
  data_t   ap_wdata;      // write data riding with address phase
  logic    ap_nonseq;
  logic    reissue;       // cancelled address phase to present again
  logic    err_first;     // first cycle of the error response

  assign ap_nonseq = HTRANS == `HTRANS_NONSEQ;
  assign err_first = (dp_state == DP_BUSY) & ~HREADY & HRESP;

  // head taken in the cycle its address phase starts
  assign pop_o     = HREADY & ~reissue & ~empty_i;

  ////////////////////////////////////////////////////////////
  // fixed transfer attributes
  ////////////////////////////////////////////////////////////

  assign HBURST    = `HBURST_SINGLE;   // no bursts from wishbone classic
  assign HPROT     = `HPROT_DFLT;
  assign HMASTLOCK = 1'b0;
  assign HWDATA    = dp_wdata;

  ////////////////////////////////////////////////////////////
  // address phase and data phase tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK, negedge HRESETn)
    if (!HRESETn)
    begin
      HSEL     <= 1'b0;
      HTRANS   <= `HTRANS_IDLE;
      HADDR    <= '0;
      HWRITE   <= 1'b0;
      HSIZE    <= `HSIZE_WORD;
      dp_state <= DP_IDLE;
      dp_we    <= 1'b0;
      reissue  <= 1'b0;
    end
    else if (HREADY)
    begin
      // presented address phase moves into data phase
      dp_state <= ap_nonseq ? DP_BUSY : DP_IDLE;
      dp_we    <= HWRITE;
      if (reissue)                    // address regs still hold it
      begin
        HSEL    <= 1'b1;
        HTRANS  <= `HTRANS_NONSEQ;
        reissue <= 1'b0;
      end
      else if (!empty_i)
      begin
        HSEL   <= 1'b1;
        HTRANS <= `HTRANS_NONSEQ;
        HADDR  <= head_addr_i;
        HWRITE <= head_we_i;
        HSIZE  <= head_size_i;
      end
      else
      begin
        HSEL   <= 1'b0;
        HTRANS <= `HTRANS_IDLE;
      end
    end
    else if (err_first)
    begin
      // idle during the second error cycle
      HSEL    <= 1'b0;
      HTRANS  <= `HTRANS_IDLE;
      reissue <= ap_nonseq;
    end

  // write data follows its transfer one phase behind
  always_ff @(posedge HCLK)
  begin
    if (pop_o)
      ap_wdata <= head_data_i;
    if (HREADY && ap_nonseq)
      dp_wdata <= ap_wdata;
  end

  // data phase ends on HREADY, error or not
  assign rsp_valid_o = (dp_state == DP_BUSY) & HREADY;
  assign rsp_we_o    = dp_we;
  assign rsp_err_o   = HRESP;
  assign rsp_rdata_o = HRDATA;

endmodule

// File: build.f
+incdir+.
ahb_biu_pkg.sv
wb_req_capture.sv
req_fifo.sv
ahb_master.sv
ahb_biu_top.sv
tb_ahb_slave.sv
tb_ahb_biu.sv

// File: req_fifo.sv
////////////////////////////////////////////////////////////
// Request buffer
// synchronous FIFO of bus requests between the Wishbone
// capture and the AHB master, push and pop in one cycle
////////////////////////////////////////////////////////////

`include "ahb_biu_consts.svh"

module req_fifo
#(
  parameter int DEPTH = `REQ_DEPTH      // power of two
)
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 push_i,
  input  logic                 push_we_i,
  input  ahb_biu_pkg::addr_t   push_addr_i,
  input  ahb_biu_pkg::hsize_t  push_size_i,
  input  ahb_biu_pkg::data_t   push_data_i,
  output logic                 full_o,
  input  logic                 pop_i,
  output logic                 empty_o,
  output logic                 head_we_o,
  output ahb_biu_pkg::addr_t   head_addr_o,
  output ahb_biu_pkg::hsize_t  head_size_o,
  output ahb_biu_pkg::data_t   head_data_o
);
  import ahb_biu_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [DEPTH-1:0] we_q;
  addr_t            addr_q [DEPTH];
  hsize_t           size_q [DEPTH];
  data_t            data_q [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;           // one bit wider, holds DEPTH
  logic             do_push;
  logic             do_pop;

  assign full_o  = count == (AW+1)'(DEPTH);
  assign empty_o = count == '0;
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge HCLK, negedge HRESETn)
    if (!HRESETn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                            // both or none
      endcase
    end

  // entry storage
  always_ff @(posedge HCLK)
    if (do_push)
    begin
      we_q[wr_ptr]   <= push_we_i;
      addr_q[wr_ptr] <= push_addr_i;
      size_q[wr_ptr] <= push_size_i;
      data_q[wr_ptr] <= push_data_i;
    end

  assign head_we_o   = we_q[rd_ptr];
  assign head_addr_o = addr_q[rd_ptr];
  assign head_size_o = size_q[rd_ptr];
  assign head_data_o = data_q[rd_ptr];

endmodule

// File: tb_ahb_biu.sv
////////////////////////////////////////////////////////////
// AHB bus interface unit testbench
// random wishbone traffic from an xorshift source, checked
// against a byte array model of the AHB memory
////////////////////////////////////////////////////////////

`include "ahb_biu_consts.svh"

module tb_ahb_biu;
  import ahb_biu_pkg::*;

  localparam int WAIT_MAX = 200;      // cycles per handshake

  logic     HCLK;
  logic     HRESETn;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  addr_t    wb_adr_i;
  data_t    wb_dat_i;
  sel_t     wb_sel_i;
  data_t    wb_dat_o;
  logic     wb_ack_o;
  logic     wb_err_o;
  logic     wr_err_o;
  logic     HSEL;
  addr_t    HADDR;
  logic     HWRITE;
  hsize_t   HSIZE;
  logic [2:0] HBURST;
  hprot_t   HPROT;
  htrans_t  HTRANS;
  logic     HMASTLOCK;
  data_t    HWDATA;
  data_t    HRDATA;
  logic     HREADY;
  logic     HRESP;

  logic [7:0]  model [1024];   // expected memory bytes
  logic        exp_wr_err;     // expected sticky flag
  logic [31:0] rng;

  ahb_biu_top dut_i (.*);
  tb_ahb_slave u_mem (.*);

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  ////////////////////////////////////////////////////////////
  // helpers and model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] fill_byte(input int i);
    return 8'(i) ^ 8'(i >> 2) ^ 8'h5a;      // matches the memory preload
  endfunction

  function automatic addr_t mem_addr(input logic [31:0] r);
    return {22'd0, r[9:2], 2'b00};          // word inside 1 KiB
  endfunction

  function automatic logic in_err_region(input addr_t a);
    return (a & `ERR_MASK) == `ERR_BASE;
  endfunction

  // aligned lane groups only
  function automatic logic sel_legal(input sel_t s);
    case (s)
      4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic sel_t pick_sel(input logic [2:0] k);
    case (k)
      3'd0:    return 4'b0001;
      3'd1:    return 4'b0010;
      3'd2:    return 4'b0100;
      3'd3:    return 4'b1000;
      3'd4:    return 4'b0011;
      3'd5:    return 4'b1100;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic data_t model_word(input addr_t a);
    data_t w;
    for (int i = 0; i < 4; i++)
      w[8*i +: 8] = model[4*a[9:2] + i];
    return w;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t: %s gave %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_resp(input logic got_err, input logic exp_err, input string what);
    if (got_err !== exp_err)
      abort_run($sformatf("FAILED at %0t: %s was %s, expected %s", $time, what,
                          got_err ? "err" : "ack", exp_err ? "err" : "ack"));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // fixed attributes of every issued transfer
  always @(negedge HCLK)
    if (HTRANS == `HTRANS_NONSEQ)
    begin
      check_flag(HSEL, 1'b1, "HSEL with NONSEQ");
      check_flag(HBURST == `HBURST_SINGLE, 1'b1, "HBURST single");
      check_flag(HPROT == `HPROT_DFLT, 1'b1, "HPROT default");
      check_flag(HMASTLOCK, 1'b0, "HMASTLOCK");
    end

  ////////////////////////////////////////////////////////////
  // wishbone accesses called and returning on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input logic we, input addr_t adr, input data_t dat,
                            input sel_t sel, output logic got_err, output data_t got_data);
    int n;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    n = 0;
    @(negedge HCLK);
    while (!wb_ack_o && !wb_err_o && n < WAIT_MAX)
    begin
      @(negedge HCLK);
      n++;
    end
    if (!wb_ack_o && !wb_err_o)
      abort_run($sformatf("timeout: the %s of address %h got neither ack nor err",
                          we ? "write" : "read", adr));
    check_flag(wb_ack_o & wb_err_o, 1'b0, "ack and err together");
    got_err  = wb_err_o;
    got_data = wb_dat_o;
    wb_cyc_i = 1'b0;                 // next access may raise it again at once
    wb_stb_i = 1'b0;
  endtask

  task automatic do_write(input addr_t adr, input data_t dat, input sel_t sel);
    logic  err;
    data_t rdata;
    bus_access(1'b1, adr, dat, sel, err, rdata);
    check_resp(err, !sel_legal(sel), $sformatf("write of %h sel %b", adr, sel));
    if (sel_legal(sel))
    begin
      if (in_err_region(adr))
        exp_wr_err = 1'b1;           // posted write error shows up later
      else
        for (int i = 0; i < 4; i++)
          if (sel[i])
            model[4*adr[9:2] + i] = dat[8*i +: 8];
    end
  endtask

  task automatic do_read(input addr_t adr);
    logic  err;
    data_t rdata;
    bus_access(1'b0, adr, '0, 4'b1111, err, rdata);
    check_resp(err, in_err_region(adr), $sformatf("read of %h", adr));
    if (!err)
      check_data(rdata, model_word(adr), $sformatf("read of %h", adr));
    check_flag(wr_err_o, exp_wr_err, "wr_err_o after read");   // older writes done
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    addr_t       a;
    sel_t        s;
    logic [31:0] base;
    HRESETn    = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    wb_sel_i   = '0;
    rng        = 32'd32884;
    exp_wr_err = 1'b0;
    for (int i = 0; i < 1024; i++)
      model[i] = fill_byte(i);
    repeat (8) @(negedge HCLK);
    check_flag(HSEL, 1'b0, "HSEL in reset");
    check_flag(HTRANS == `HTRANS_IDLE, 1'b1, "HTRANS idle in reset");
    check_flag(wb_ack_o | wb_err_o | wr_err_o, 1'b0, "wishbone outputs in reset");
    HRESETn = 1'b1;

    repeat (16)                      // word write then read back
    begin
      rng = xorshift32(rng);
      a   = mem_addr(rng);
      rng = xorshift32(rng);
      do_write(a, rng, 4'b1111);
      do_read(a);
    end

    repeat (48)                      // byte and halfword lanes
    begin
      rng = xorshift32(rng);
      a   = mem_addr(rng);
      s   = pick_sel(rng[12:10]);
      rng = xorshift32(rng);
      do_write(a, rng, s);
      do_read(a);
    end

    repeat (12)                      // posted bursts fill the buffer
    begin
      rng  = xorshift32(rng);
      base = rng;
      for (int k = 0; k < 2*`REQ_DEPTH + 2; k++)
      begin
        rng = xorshift32(rng);
        do_write({22'd0, base[9:6], rng[5:2], 2'b00}, xorshift32(rng), pick_sel(rng[8:6]));
      end
      for (int k = 0; k < 16; k++)
        do_read({22'd0, base[9:6], 6'd0} + 4*k);
    end

    repeat (4)                       // read error then normal read
    begin
      rng = xorshift32(rng);
      do_read(`ERR_BASE | mem_addr(rng));
      do_read(mem_addr(rng >> 10));
    end

    check_flag(wr_err_o, 1'b0, "wr_err_o before any write error");
    rng = xorshift32(rng);
    do_write(`ERR_BASE | mem_addr(rng), rng, 4'b1111);
    do_read(mem_addr(rng >> 12));    // flag must be up by now

    repeat (8)                       // illegal selects
    begin
      rng = xorshift32(rng);
      s   = rng[3:0];
      if (sel_legal(s))
        s = 4'b0101;
      a = mem_addr(rng >> 4);
      do_write(a, ~rng, s);
      do_read(a);
    end

    repeat (300)                     // mixed traffic
    begin
      rng = xorshift32(rng);
      a   = mem_addr(rng >> 8);
      if (rng[7:4] == 4'd0)
        a = a | `ERR_BASE;
      if (rng[1:0] == 2'd0)
        do_read(a);
      else if (rng[19:16] == 4'd0)
        do_write(a, xorshift32(rng), 4'b0110);
      else
        do_write(a, xorshift32(rng), pick_sel(rng[4:2]));
    end
    do_read(mem_addr(32'd0));        // drain posted writes

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: tb_ahb_slave.sv
////////////////////////////////////////////////////////////
// AHB memory for the testbench
// 1 KiB of byte lanes behind an AHB3-Lite slave port,
// random wait states, two cycle ERROR in the error region
////////////////////////////////////////////////////////////

`include "ahb_biu_consts.svh"

module tb_ahb_slave
#(
  parameter logic [31:0] SEED = 32'd32884
)
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 HSEL,
  input  ahb_biu_pkg::addr_t   HADDR,
  input  logic                 HWRITE,
  input  ahb_biu_pkg::hsize_t  HSIZE,
  input  ahb_biu_pkg::htrans_t HTRANS,
  input  ahb_biu_pkg::data_t   HWDATA,
  output ahb_biu_pkg::data_t   HRDATA,
  output logic                 HREADY,
  output logic                 HRESP
);
  import ahb_biu_pkg::*;

  logic [7:0]  mem [1024];
  logic        active;      // transfer in data phase
  logic        dp_write;
  addr_t       dp_addr;
  hsize_t      dp_size;
  logic        dp_err;      // address hit the error region
  logic        err_stage;   // second error cycle
  logic [2:0]  wait_cnt;    // wait states left
  logic [31:0] rng;
  logic [9:0]  wbase;       // byte index of lane 0

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // byte lanes touched by a transfer of this size and offset
  function automatic logic lane_hit(input hsize_t size, input logic [1:0] off, input int lane);
    case (size)
      `HSIZE_BYTE:  return lane == off;
      `HSIZE_HWORD: return (lane >> 1) == off[1];
      default:      return 1'b1;            // full word
    endcase
  endfunction

  initial
    for (int i = 0; i < 1024; i++)
      mem[i] = 8'(i) ^ 8'(i >> 2) ^ 8'h5a;  // every address bit counts

  assign wbase  = {dp_addr[9:2], 2'b00};
  assign HREADY = !active || (dp_err ? err_stage : wait_cnt == 3'd0);
  assign HRESP  = active && dp_err;        // both error cycles
  assign HRDATA = {mem[wbase + 3], mem[wbase + 2], mem[wbase + 1], mem[wbase]};

  always_ff @(posedge HCLK, negedge HRESETn)
    if (!HRESETn)
    begin
      active    <= 1'b0;
      dp_write  <= 1'b0;
      dp_addr   <= '0;
      dp_size   <= `HSIZE_WORD;
      dp_err    <= 1'b0;
      err_stage <= 1'b0;
      wait_cnt  <= 3'd0;
      rng       <= SEED;
    end
    else if (HREADY)
    begin
      // sample the next address phase
      active    <= HSEL && HTRANS == `HTRANS_NONSEQ;
      dp_write  <= HWRITE;
      dp_addr   <= HADDR;
      dp_size   <= HSIZE;
      dp_err    <= (HADDR & `ERR_MASK) == `ERR_BASE;
      err_stage <= 1'b0;
      rng       <= xorshift32(rng);
      wait_cnt  <= rng[2:0] & {rng[3], rng[3], 1'b1};   // mostly short, now and then long
    end
    else if (dp_err)
      err_stage <= 1'b1;
    else
      wait_cnt <= wait_cnt - 3'd1;

  // write lands when the data phase closes
  always @(posedge HCLK)
    if (HRESETn && active && HREADY && dp_write && !dp_err)
      for (int i = 0; i < 4; i++)
        if (lane_hit(dp_size, dp_addr[1:0], i))
          mem[wbase + i] <= HWDATA[8*i +: 8];

endmodule

// File: wb_req_capture.sv
////////////////////////////////////////////////////////////
// Wishbone request capture
// wishbone classic slave in front of the request buffer;
// posts writes with an immediate ack, holds reads until
// the AHB response returns, flags illegal byte selects
////////////////////////////////////////////////////////////

`include "ahb_biu_consts.svh"

module wb_req_capture
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  // wishbone classic slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  ahb_biu_pkg::addr_t   wb_adr_i,
  input  ahb_biu_pkg::data_t   wb_dat_i,
  input  ahb_biu_pkg::sel_t    wb_sel_i,
  output ahb_biu_pkg::data_t   wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 wr_err_o,      // sticky posted write error
  // request buffer push
  output logic                 push_o,
  output logic                 push_we_o,
  output ahb_biu_pkg::addr_t   push_addr_o,
  output ahb_biu_pkg::hsize_t  push_size_o,
  output ahb_biu_pkg::data_t   push_data_o,
  input  logic                 full_i,
  // transfer responses, in issue order
  input  logic                 rsp_valid_i,
  input  logic                 rsp_we_i,
  input  logic                 rsp_err_i,
  input  ahb_biu_pkg::data_t   rsp_rdata_i
);
  import ahb_biu_pkg::*;

  logic       req;        // new cycle on the bus
  logic       rd_wait;    // read in flight
  logic       sel_ok;
  logic [1:0] byte_off;   // lowest active lane
  hsize_t     sel_size;

  // select decode; only naturally aligned lane groups
  always_comb
  begin
    sel_ok   = 1'b1;
    byte_off = 2'd0;
    sel_size = `HSIZE_BYTE;
    case (wb_sel_i)
      4'b0001: byte_off = 2'd0;
      4'b0010: byte_off = 2'd1;
      4'b0100: byte_off = 2'd2;
      4'b1000: byte_off = 2'd3;
      4'b0011: sel_size = `HSIZE_HWORD;
      4'b1100:
      begin
        byte_off = 2'd2;
        sel_size = `HSIZE_HWORD;
      end
      4'b1111: sel_size = `HSIZE_WORD;
      default: sel_ok   = 1'b0;
    endcase
  end

  // stb is still up in the answer cycle, skip it
  assign req         = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o & ~rd_wait;
  assign push_o      = req & sel_ok & ~full_i;
  assign push_we_o   = wb_we_i;
  assign push_addr_o = {wb_adr_i[`ADDR_W-1:2], byte_off};
  assign push_size_o = sel_size;
  assign push_data_o = wb_dat_i;    // lanes already in place

  always_ff @(posedge HCLK, negedge HRESETn)
    if (!HRESETn)
    begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      wr_err_o <= 1'b0;
      rd_wait  <= 1'b0;
    end
    else
    begin
      wb_ack_o <= push_o & push_we_o;   // posted write
      wb_err_o <= req & ~sel_ok;        // illegal select
      if (push_o && !push_we_o)
        rd_wait <= 1'b1;
      if (rsp_valid_i && !rsp_we_i)     // read completes
      begin
        rd_wait  <= 1'b0;
        wb_ack_o <= ~rsp_err_i;
        wb_err_o <= rsp_err_i;
      end
      if (rsp_valid_i && rsp_we_i && rsp_err_i)
        wr_err_o <= 1'b1;               // held until reset
    end

  // read data, valid with the ack
  always_ff @(posedge HCLK)
    if (rsp_valid_i && !rsp_we_i)
      wb_dat_o <= rsp_rdata_i;

endmodule
